// ==== verilog/obstacle_pkg.sv ====
package obstacle_pkg;

    // Pixel column, wide enough for the full line including blanking
    typedef logic [10:0] xcoord_t;

    // Line number within the frame
    typedef logic [9:0] ycoord_t;

    // Obstacle width or height in pixels
    typedef logic [7:0] extent_t;

    // Colour index, 0 is background and also marks an empty slot
    typedef logic [3:0] color_t;

    // Obstacle slot number
    typedef logic [3:0] slot_t;

    // One obstacle record, 41 bits
    // Field order from MSB: x, y, w, h, color
    typedef struct packed {
        xcoord_t x;
        ycoord_t y;
        extent_t w;
        extent_t h;
        color_t  color;
    } obstacle_t;

    // Slots in the table
    localparam int n_slots = 16;

endpackage

// ==== verilog/raster_timing.sv ====
`timescale 1ns/1ps

module raster_timing #(
    parameter obstacle_pkg::xcoord_t h_active     = 11'd640,
    parameter obstacle_pkg::xcoord_t h_sync_start = 11'd656,
    parameter obstacle_pkg::xcoord_t h_sync_end   = 11'd752,
    parameter obstacle_pkg::xcoord_t h_total      = 11'd800,
    parameter obstacle_pkg::ycoord_t v_active     = 10'd480,
    parameter obstacle_pkg::ycoord_t v_sync_start = 10'd490,
    parameter obstacle_pkg::ycoord_t v_sync_end   = 10'd492,
    parameter obstacle_pkg::ycoord_t v_total      = 10'd525
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output obstacle_pkg::xcoord_t hcount,
    output obstacle_pkg::ycoord_t vcount,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  active
);

    // Last column and last line before wrap
    localparam obstacle_pkg::xcoord_t h_last = h_total - 11'd1;
    localparam obstacle_pkg::ycoord_t v_last = v_total - 10'd1;

    logic h_wrap;
    logic v_wrap;

    ////////////////////////////////////////
    // Counters
    ////////////////////////////////////////

    assign h_wrap = (hcount == h_last);
    assign v_wrap = (vcount == v_last);

    // Column counter, one step per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
        end else if (h_wrap) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    // Line counter, steps at end of each line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vcount <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 10'd1;
            end
        end
    end

    ////////////////////////////////////////
    // Sync and active levels
    ////////////////////////////////////////

    // Active high syncs
    // End bounds are exclusive
    assign hsync = (hcount >= h_sync_start) && (hcount < h_sync_end);
    assign vsync = (vcount >= v_sync_start) && (vcount < v_sync_end);

    // Visible area
    assign active = (hcount < h_active) && (vcount < v_active);

endmodule

// ==== verilog/obstacle_table.sv ====
`timescale 1ns/1ps

module obstacle_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  obstacle_pkg::slot_t     load_slot,
    input  obstacle_pkg::obstacle_t load_data,
    output obstacle_pkg::obstacle_t obstacle_0,
    output obstacle_pkg::obstacle_t obstacle_1,
    output obstacle_pkg::obstacle_t obstacle_2,
    output obstacle_pkg::obstacle_t obstacle_3,
    output obstacle_pkg::obstacle_t obstacle_4,
    output obstacle_pkg::obstacle_t obstacle_5,
    output obstacle_pkg::obstacle_t obstacle_6,
    output obstacle_pkg::obstacle_t obstacle_7,
    output obstacle_pkg::obstacle_t obstacle_8,
    output obstacle_pkg::obstacle_t obstacle_9,
    output obstacle_pkg::obstacle_t obstacle_10,
    output obstacle_pkg::obstacle_t obstacle_11,
    output obstacle_pkg::obstacle_t obstacle_12,
    output obstacle_pkg::obstacle_t obstacle_13,
    output obstacle_pkg::obstacle_t obstacle_14,
    output obstacle_pkg::obstacle_t obstacle_15
);

    // Record storage
    obstacle_pkg::obstacle_t slots [obstacle_pkg::n_slots];

    // Reset empties every slot (colour 0)
    // Load writes one slot per strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < obstacle_pkg::n_slots; i++) begin
                slots[i] <= '0;
            end
        end else if (load) begin
            slots[load_slot] <= load_data;
        end
    end

    assign obstacle_0  = slots[0];
    assign obstacle_1  = slots[1];
    assign obstacle_2  = slots[2];
    assign obstacle_3  = slots[3];
    assign obstacle_4  = slots[4];
    assign obstacle_5  = slots[5];
    assign obstacle_6  = slots[6];
    assign obstacle_7  = slots[7];
    assign obstacle_8  = slots[8];
    assign obstacle_9  = slots[9];
    assign obstacle_10 = slots[10];
    assign obstacle_11 = slots[11];
    assign obstacle_12 = slots[12];
    assign obstacle_13 = slots[13];
    assign obstacle_14 = slots[14];
    assign obstacle_15 = slots[15];

endmodule

// ==== verilog/obstacle_mux_16_to_1.sv ====
`timescale 1ns/1ps

module obstacle_mux_16_to_1 (
    input  obstacle_pkg::obstacle_t input_0,
    input  obstacle_pkg::obstacle_t input_1,
    input  obstacle_pkg::obstacle_t input_2,
    input  obstacle_pkg::obstacle_t input_3,
    input  obstacle_pkg::obstacle_t input_4,
    input  obstacle_pkg::obstacle_t input_5,
    input  obstacle_pkg::obstacle_t input_6,
    input  obstacle_pkg::obstacle_t input_7,
    input  obstacle_pkg::obstacle_t input_8,
    input  obstacle_pkg::obstacle_t input_9,
    input  obstacle_pkg::obstacle_t input_10,
    input  obstacle_pkg::obstacle_t input_11,
    input  obstacle_pkg::obstacle_t input_12,
    input  obstacle_pkg::obstacle_t input_13,
    input  obstacle_pkg::obstacle_t input_14,
    input  obstacle_pkg::obstacle_t input_15,
    input  obstacle_pkg::slot_t     select,
    output obstacle_pkg::obstacle_t obstacle_mux_out
);

    // Purely combinational pick of one record
    // All sixteen codes covered so no latch
    always_comb begin
        case (select)
            4'b0000: obstacle_mux_out = input_0;
            4'b0001: obstacle_mux_out = input_1;
            4'b0010: obstacle_mux_out = input_2;
            4'b0011: obstacle_mux_out = input_3;
            4'b0100: obstacle_mux_out = input_4;
            4'b0101: obstacle_mux_out = input_5;
            4'b0110: obstacle_mux_out = input_6;
            4'b0111: obstacle_mux_out = input_7;

            4'b1000: obstacle_mux_out = input_8;
            4'b1001: obstacle_mux_out = input_9;
            4'b1010: obstacle_mux_out = input_10;
            4'b1011: obstacle_mux_out = input_11;
            4'b1100: obstacle_mux_out = input_12;
            4'b1101: obstacle_mux_out = input_13;
            4'b1110: obstacle_mux_out = input_14;
            4'b1111: obstacle_mux_out = input_15;
        endcase
    end

endmodule

// ==== verilog/line_scanner.sv ====
`timescale 1ns/1ps

module line_scanner #(
    parameter obstacle_pkg::xcoord_t h_active = 11'd640,
    parameter obstacle_pkg::ycoord_t v_total  = 10'd525
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  obstacle_pkg::xcoord_t   hcount,
    input  obstacle_pkg::ycoord_t   vcount,
    output obstacle_pkg::slot_t     select,
    input  obstacle_pkg::obstacle_t obstacle,
    output logic                    span_valid [obstacle_pkg::n_slots],
    output obstacle_pkg::xcoord_t   span_x0    [obstacle_pkg::n_slots],
    output obstacle_pkg::xcoord_t   span_x1    [obstacle_pkg::n_slots],
    output obstacle_pkg::color_t    span_color [obstacle_pkg::n_slots]
);

    localparam obstacle_pkg::ycoord_t v_last    = v_total - 10'd1;
    localparam obstacle_pkg::slot_t   last_slot = obstacle_pkg::slot_t'(obstacle_pkg::n_slots - 1);

    typedef enum logic {
        idle,
        scan
    } scan_state_t;

    scan_state_t           state;
    obstacle_pkg::slot_t   slot;
    obstacle_pkg::ycoord_t target_line;
    logic                  start;
    logic [10:0]           y_end;
    logic                  hit;

    // Scan kicks off at the first blanking column
    assign start  = (state == idle) && (hcount == h_active);
    assign select = slot;

    ////////////////////////////////////////
    // Vertical overlap test
    ////////////////////////////////////////

    // Bottom edge, exclusive, one bit wider so y + h cannot wrap
    assign y_end = {1'b0, obstacle.y} + {3'b000, obstacle.h};

    // Empty slots never hit
    assign hit = (obstacle.color != '0) &&
                 (obstacle.y <= target_line) &&
                 ({1'b0, target_line} < y_end);

    ////////////////////////////////////////
    // FSM and valid flags
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            slot  <= '0;
            for (int i = 0; i < obstacle_pkg::n_slots; i++) begin
                span_valid[i] <= 1'b0;
            end
        end else begin
            case (state)
                idle: begin
                    // Drop last line's spans before refill
                    if (start) begin
                        for (int i = 0; i < obstacle_pkg::n_slots; i++) begin
                            span_valid[i] <= 1'b0;
                        end
                        slot  <= '0;
                        state <= scan;
                    end
                end
                scan: begin
                    // One slot per cycle, mux output read same cycle
                    span_valid[slot] <= hit;
                    slot             <= slot + 4'd1;
                    if (slot == last_slot) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Next line number, wraps after last line
    always_ff @(posedge clk) begin
        if (start) begin
            target_line <= (vcount == v_last) ? '0 : vcount + 10'd1;
        end
    end

    // Horizontal span, x1 exclusive
    // Span index is the slot number
    always_ff @(posedge clk) begin
        if (state == scan) begin
            span_x0[slot]    <= obstacle.x;
            span_x1[slot]    <= obstacle.x + obstacle_pkg::xcoord_t'(obstacle.w);
            span_color[slot] <= obstacle.color;
        end
    end

endmodule

// ==== verilog/span_painter.sv ====
`timescale 1ns/1ps

module span_painter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  obstacle_pkg::xcoord_t hcount,
    input  logic                  hsync_in,
    input  logic                  vsync_in,
    input  logic                  active_in,
    input  logic                  span_valid [obstacle_pkg::n_slots],
    input  obstacle_pkg::xcoord_t span_x0    [obstacle_pkg::n_slots],
    input  obstacle_pkg::xcoord_t span_x1    [obstacle_pkg::n_slots],
    input  obstacle_pkg::color_t  span_color [obstacle_pkg::n_slots],
    output logic                  hsync,
    output logic                  vsync,
    output logic                  active,
    output obstacle_pkg::color_t  pixel_color
);

    logic                 covers [obstacle_pkg::n_slots];
    obstacle_pkg::color_t color_next;

    ////////////////////////////////////////
    // Range compares
    ////////////////////////////////////////

    // Column inside [x0, x1) of a valid span
    always_comb begin
        for (int i = 0; i < obstacle_pkg::n_slots; i++) begin
            covers[i] = span_valid[i] &&
                        (hcount >= span_x0[i]) &&
                        (hcount < span_x1[i]);
        end
    end

    // Priority pick
    // Walk from highest slot down so lowest slot overwrites last
    always_comb begin
        color_next = '0;
        for (int i = obstacle_pkg::n_slots - 1; i >= 0; i--) begin
            if (covers[i]) begin
                color_next = span_color[i];
            end
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    // Syncs delayed one cycle to line up with the colour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            active      <= 1'b0;
            pixel_color <= '0;
        end else begin
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            active <= active_in;
            // Background outside visible area
            if (active_in) begin
                pixel_color <= color_next;
            end else begin
                pixel_color <= '0;
            end
        end
    end

endmodule

// ==== verilog/obstacle_draw_top.sv ====
`timescale 1ns/1ps

module obstacle_draw_top #(
    parameter obstacle_pkg::xcoord_t h_active     = 11'd640,
    parameter obstacle_pkg::xcoord_t h_sync_start = 11'd656,
    parameter obstacle_pkg::xcoord_t h_sync_end   = 11'd752,
    parameter obstacle_pkg::xcoord_t h_total      = 11'd800,
    parameter obstacle_pkg::ycoord_t v_active     = 10'd480,
    parameter obstacle_pkg::ycoord_t v_sync_start = 10'd490,
    parameter obstacle_pkg::ycoord_t v_sync_end   = 10'd492,
    parameter obstacle_pkg::ycoord_t v_total      = 10'd525
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  obstacle_pkg::slot_t     load_slot,
    input  obstacle_pkg::obstacle_t load_data,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    active,
    output obstacle_pkg::color_t    pixel_color
);

    // Raster counters and raw levels
    obstacle_pkg::xcoord_t   hcount;
    obstacle_pkg::ycoord_t   vcount;
    logic                    raw_hsync;
    logic                    raw_vsync;
    logic                    raw_active;

    // Table records and mux path
    obstacle_pkg::obstacle_t table_rec [obstacle_pkg::n_slots];
    obstacle_pkg::slot_t     mux_select;
    obstacle_pkg::obstacle_t mux_out;

    // Span list for the line being drawn
    logic                    span_valid [obstacle_pkg::n_slots];
    obstacle_pkg::xcoord_t   span_x0    [obstacle_pkg::n_slots];
    obstacle_pkg::xcoord_t   span_x1    [obstacle_pkg::n_slots];
    obstacle_pkg::color_t    span_color [obstacle_pkg::n_slots];

    ////////////////////////////////////////
    // Timing
    ////////////////////////////////////////

    raster_timing #(
        .h_active     (h_active),
        .h_sync_start (h_sync_start),
        .h_sync_end   (h_sync_end),
        .h_total      (h_total),
        .v_active     (v_active),
        .v_sync_start (v_sync_start),
        .v_sync_end   (v_sync_end),
        .v_total      (v_total)
    ) raster_timing_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (raw_hsync),
        .vsync  (raw_vsync),
        .active (raw_active)
    );

    ////////////////////////////////////////
    // Table and mux
    ////////////////////////////////////////

    obstacle_table obstacle_table_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .load_slot   (load_slot),
        .load_data   (load_data),
        .obstacle_0  (table_rec[0]),
        .obstacle_1  (table_rec[1]),
        .obstacle_2  (table_rec[2]),
        .obstacle_3  (table_rec[3]),
        .obstacle_4  (table_rec[4]),
        .obstacle_5  (table_rec[5]),
        .obstacle_6  (table_rec[6]),
        .obstacle_7  (table_rec[7]),
        .obstacle_8  (table_rec[8]),
        .obstacle_9  (table_rec[9]),
        .obstacle_10 (table_rec[10]),
        .obstacle_11 (table_rec[11]),
        .obstacle_12 (table_rec[12]),
        .obstacle_13 (table_rec[13]),
        .obstacle_14 (table_rec[14]),
        .obstacle_15 (table_rec[15])
    );

    obstacle_mux_16_to_1 obstacle_mux_inst (
        .input_0          (table_rec[0]),
        .input_1          (table_rec[1]),
        .input_2          (table_rec[2]),
        .input_3          (table_rec[3]),
        .input_4          (table_rec[4]),
        .input_5          (table_rec[5]),
        .input_6          (table_rec[6]),
        .input_7          (table_rec[7]),
        .input_8          (table_rec[8]),
        .input_9          (table_rec[9]),
        .input_10         (table_rec[10]),
        .input_11         (table_rec[11]),
        .input_12         (table_rec[12]),
        .input_13         (table_rec[13]),
        .input_14         (table_rec[14]),
        .input_15         (table_rec[15]),
        .select           (mux_select),
        .obstacle_mux_out (mux_out)
    );

    ////////////////////////////////////////
    // Scanner and painter
    ////////////////////////////////////////

    line_scanner #(
        .h_active (h_active),
        .v_total  (v_total)
    ) line_scanner_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .hcount     (hcount),
        .vcount     (vcount),
        .select     (mux_select),
        .obstacle   (mux_out),
        .span_valid (span_valid),
        .span_x0    (span_x0),
        .span_x1    (span_x1),
        .span_color (span_color)
    );

    span_painter span_painter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .hcount      (hcount),
        .hsync_in    (raw_hsync),
        .vsync_in    (raw_vsync),
        .active_in   (raw_active),
        .span_valid  (span_valid),
        .span_x0     (span_x0),
        .span_x1     (span_x1),
        .span_color  (span_color),
        .hsync       (hsync),
        .vsync       (vsync),
        .active      (active),
        .pixel_color (pixel_color)
    );

endmodule

// ==== bench/obstacle_draw_tb.sv ====
`timescale 1ns/1ps

module obstacle_draw_tb;

    // Default 640x480 raster timing
    localparam int h_active_tb     = 640;
    localparam int h_sync_start_tb = 656;
    localparam int h_sync_end_tb   = 752;
    localparam int h_total_tb      = 800;
    localparam int v_active_lines  = 480;
    localparam int v_sync_start_tb = 490;
    localparam int v_sync_end_tb   = 492;
    localparam int v_total_tb      = 525;
    localparam int reset_cycles    = 10;

    logic                    clk;
    logic                    rst_n;
    logic                    load;
    obstacle_pkg::slot_t     load_slot;
    obstacle_pkg::obstacle_t load_data;
    logic                    hsync;
    logic                    vsync;
    logic                    active;
    obstacle_pkg::color_t    pixel_color;

    // Stimulus from the data file tagged with its phase
    int                      ld_phase_q [$];
    obstacle_pkg::slot_t     ld_slot_q  [$];
    obstacle_pkg::obstacle_t ld_data_q  [$];
    int                      pr_phase_q [$];
    int                      pr_x_q     [$];
    int                      pr_y_q     [$];
    int                      n_phases;

    // Expected colour per probe
    // Key packs phase, line and column
    int exp_map  [int];
    bit seen_map [int];

    // Handshake between main sequence and pixel monitor
    int cur_phase;
    bit armed;
    bit in_frame;
    bit frame_done;

    // Pixel position rebuilt from DUT outputs
    int col;
    int line;
    int lines_done;
    bit prev_active;
    bit prev_vsync;

    // Free running raster position for the level checks
    int hpos;
    int vpos;
    bit pos_valid;
    bit hsync_exp;
    bit vsync_exp;
    bit active_exp;

    int mon_mismatches;
    int main_mismatches;
    int missed_probes;
    int stim_errors;
    int cycle_count;
    int cycle_limit = 3 * h_total_tb * v_total_tb + reset_cycles + 4;

    obstacle_draw_top obstacle_draw_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .load_slot   (load_slot),
        .load_data   (load_data),
        .hsync       (hsync),
        .vsync       (vsync),
        .active      (active),
        .pixel_color (pixel_color)
    );

    always #5 clk = ~clk;

    function automatic int probe_key(int phase, int x, int y);
        return phase * 1048576 + y * 1024 + x;
    endfunction

    ////////////////////////////////////////
    // Stimulus file
    ////////////////////////////////////////

    // Lines hold L slot x y w h color or P x y color
    // Hash lines are comments
    task automatic read_stimulus();
        int                      fd;
        int                      c;
        int                      code;
        int                      a, b, d, e, f, g;
        int                      phase;
        bit                      last_probe;
        logic [7:0]              ch;
        obstacle_pkg::obstacle_t rec;
        phase      = 0;
        last_probe = 1'b0;
        fd = $fopen("bench/obstacle_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/obstacle_stimulus.txt");
            stim_errors = stim_errors + 1;
            n_phases    = 0;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                ch = 8'(c);
                if (ch == "#") begin
                    // Skip rest of comment line
                    while (c != -1 && c != 10) begin
                        c = $fgetc(fd);
                    end
                end else if (ch == "L") begin
                    code = $fscanf(fd, "%d %d %d %d %d %d", a, b, d, e, f, g);
                    if (code != 6) begin
                        $display("A load line in the stimulus file could not be read");
                        stim_errors = stim_errors + 1;
                    end
                    // A load after probes opens the next phase
                    if (last_probe) begin
                        phase      = phase + 1;
                        last_probe = 1'b0;
                    end
                    rec.x     = obstacle_pkg::xcoord_t'(b);
                    rec.y     = obstacle_pkg::ycoord_t'(d);
                    rec.w     = obstacle_pkg::extent_t'(e);
                    rec.h     = obstacle_pkg::extent_t'(f);
                    rec.color = obstacle_pkg::color_t'(g);
                    ld_phase_q.push_back(phase);
                    ld_slot_q.push_back(obstacle_pkg::slot_t'(a));
                    ld_data_q.push_back(rec);
                end else if (ch == "P") begin
                    code = $fscanf(fd, "%d %d %d", a, b, d);
                    if (code != 3) begin
                        $display("A probe line in the stimulus file could not be read");
                        stim_errors = stim_errors + 1;
                    end
                    last_probe = 1'b1;
                    pr_phase_q.push_back(phase);
                    pr_x_q.push_back(a);
                    pr_y_q.push_back(b);
                    exp_map[probe_key(phase, a, b)] = d;
                end
                if (c != -1) begin
                    c = $fgetc(fd);
                end
            end
            $fclose(fd);
            n_phases = phase + 1;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence helpers
    ////////////////////////////////////////

    task automatic check_idle_outputs();
        if (hsync !== 1'b0 || vsync !== 1'b0 || active !== 1'b0 || pixel_color !== 4'd0) begin
            $display("Mismatch at %0t: outputs around reset, expected all 0 seen %b %b %b %0d",
                     $time, hsync, vsync, active, pixel_color);
            main_mismatches = main_mismatches + 1;
        end
    endtask

    // Strobe one record into the table
    task automatic drive_load(obstacle_pkg::slot_t slot, obstacle_pkg::obstacle_t rec);
        @(posedge clk);
        #1;
        load      = 1'b1;
        load_slot = slot;
        load_data = rec;
    endtask

    task automatic check_probes_reached(int phase);
        for (int i = 0; i < pr_x_q.size(); i++) begin
            if (pr_phase_q[i] == phase &&
                !seen_map.exists(probe_key(phase, pr_x_q[i], pr_y_q[i]))) begin
                $display("Probe at column %0d line %0d was never reached", pr_x_q[i], pr_y_q[i]);
                missed_probes = missed_probes + 1;
            end
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        load            = 1'b0;
        load_slot       = '0;
        load_data       = '0;
        cur_phase       = 0;
        armed           = 1'b0;
        main_mismatches = 0;
        missed_probes   = 0;
        stim_errors     = 0;
        read_stimulus();
        cycle_limit = cycle_limit + ld_slot_q.size();

        // Outputs idle through reset and the cycle after release
        repeat (reset_cycles) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();

        for (int p = 0; p < n_phases; p++) begin
            for (int i = 0; i < ld_slot_q.size(); i++) begin
                if (ld_phase_q[i] == p) begin
                    drive_load(ld_slot_q[i], ld_data_q[i]);
                end
            end
            @(posedge clk);
            #1;
            load = 1'b0;
            // Probes apply to the first frame after these loads
            cur_phase = p;
            armed     = 1'b1;
            wait (frame_done);
            check_probes_reached(p);
            @(posedge clk);
            #1;
            armed = 1'b0;
            @(posedge clk);
            #1;
        end

        $display("Errors: %0d mismatches, %0d probes missed, %0d stimulus errors",
                 main_mismatches + mon_mismatches, missed_probes, stim_errors);
        if (main_mismatches + mon_mismatches + missed_probes + stim_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    ////////////////////////////////////////
    // Pixel monitor
    ////////////////////////////////////////

    // Samples at the falling edge away from register updates
    initial begin
        col            = 0;
        line           = 0;
        lines_done     = 0;
        prev_active    = 1'b0;
        prev_vsync     = 1'b0;
        in_frame       = 1'b0;
        frame_done     = 1'b0;
        hpos           = 0;
        vpos           = 0;
        pos_valid      = 1'b0;
        mon_mismatches = 0;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            // Column restarts on each active rise
            if (active && !prev_active) begin
                col = 0;
            end else if (active) begin
                col = col + 1;
            end
            // Raster position counts on from the first active rise
            if (active && !prev_active && !pos_valid) begin
                pos_valid = 1'b1;
                hpos      = 0;
                vpos      = 0;
            end else if (pos_valid) begin
                hpos = hpos + 1;
                if (hpos == h_total_tb) begin
                    hpos = 0;
                    vpos = (vpos + 1) % v_total_tb;
                end
            end
            // Sync and active levels against the raster timing
            if (pos_valid) begin
                hsync_exp  = (hpos >= h_sync_start_tb) && (hpos < h_sync_end_tb);
                vsync_exp  = (vpos >= v_sync_start_tb) && (vpos < v_sync_end_tb);
                active_exp = (hpos < h_active_tb) && (vpos < v_active_lines);
                if (hsync !== hsync_exp || vsync !== vsync_exp || active !== active_exp) begin
                    $display("Mismatch at %0t: levels at %0d,%0d expected %b%b%b seen %b%b%b",
                             $time, hpos, vpos, hsync_exp, vsync_exp, active_exp,
                             hsync, vsync, active);
                    mon_mismatches = mon_mismatches + 1;
                end
            end
            if (vsync && !prev_vsync) begin
                line = 0;
                if (armed && !in_frame && !frame_done) begin
                    in_frame   = 1'b1;
                    lines_done = 0;
                end
            end
            // Blanking is always background
            if (!active && pixel_color != 4'd0) begin
                $display("Mismatch at %0t: colour %0d while active is low",
                         $time, pixel_color);
                mon_mismatches = mon_mismatches + 1;
            end
            if (in_frame && active && exp_map.exists(probe_key(cur_phase, col, line))) begin
                seen_map[probe_key(cur_phase, col, line)] = 1'b1;
                if (int'(pixel_color) != exp_map[probe_key(cur_phase, col, line)]) begin
                    $display("Mismatch at %0t: pixel column %0d line %0d, expected %0d seen %0d",
                             $time, col, line, exp_map[probe_key(cur_phase, col, line)],
                             pixel_color);
                    mon_mismatches = mon_mismatches + 1;
                end
            end
            // Line ends on the active fall
            if (!active && prev_active) begin
                line = line + 1;
                if (in_frame) begin
                    lines_done = lines_done + 1;
                    if (lines_done == v_active_lines) begin
                        in_frame   = 1'b0;
                        frame_done = 1'b1;
                    end
                end
            end
            if (!armed) begin
                frame_done = 1'b0;
            end
            prev_active = active;
            prev_vsync  = vsync;
        end
    end

    // Run limit of three frames plus reset and loads
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Errors: %0d mismatches, %0d probes missed, %0d stimulus errors",
                     main_mismatches + mon_mismatches, missed_probes, stim_errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        cycle_count = 0;
    end

endmodule

// ==== bench/obstacle_stimulus.txt ====
# L slot x y w h color : load one table slot
# P x y color : probe pixel and its expected colour
L 0 0 0 20 10 1
L 1 100 50 40 30 3
L 2 300 200 50 50 5
L 3 620 470 20 10 2
L 4 370 250 60 40 0
L 5 500 10 10 10 4
L 6 520 10 10 10 6
L 7 540 10 10 10 7
L 8 560 10 10 10 8
L 9 330 230 60 40 9
L 10 500 100 10 10 10
L 11 520 100 10 10 11
L 12 540 100 10 10 12
L 13 560 100 10 10 13
L 14 500 300 30 30 14
L 15 0 400 30 80 15
# Single obstacle, corners and just outside each edge
P 120 60 3
P 100 50 3
P 139 50 3
P 100 79 3
P 139 79 3
P 99 60 0
P 140 60 0
P 120 49 0
P 120 80 0
# Slot 2 over slot 9
P 320 220 5
P 340 240 5
P 349 249 5
P 350 249 9
P 340 250 9
P 360 265 9
# Empty slot 4
P 380 260 9
P 420 280 0
# Frame edges
P 0 0 1
P 19 9 1
P 20 0 0
P 0 10 0
P 0 479 15
P 639 479 2
P 639 469 0
# Remaining slots
P 505 15 4
P 525 15 6
P 545 15 7
P 565 15 8
P 505 105 10
P 525 105 11
P 545 105 12
P 565 105 13
P 510 310 14
# Slot 1 moved
L 1 200 150 40 30 3
P 120 60 0
P 200 150 3
P 239 179 3
P 240 160 0
P 220 149 0
P 340 240 5

// ==== verilog.f ====
verilog/obstacle_pkg.sv
verilog/raster_timing.sv
verilog/obstacle_table.sv
verilog/obstacle_mux_16_to_1.sv
verilog/line_scanner.sv
verilog/span_painter.sv
verilog/obstacle_draw_top.sv
bench/obstacle_draw_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the obstacle drawing testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing \
    -f verilog.f \
    --top-module obstacle_draw_tb \
    -o obstacle_draw_sim

./obj_dir/obstacle_draw_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation reported errors"
    exit 1
fi

echo "Simulation finished without errors"
